//--- gx_regs_pkg.sv
`default_nettype none

package gx_regs_pkg;

    // Sprite count and sprite select width
    localparam int NUM_SPRITES  = 8;
    localparam int SPRITE_IDX_W = 3;

    // Low byte of the register map
    localparam logic [7:0] ADDR_SCREEN_X      = 8'h80;
    localparam logic [7:0] ADDR_SCREEN_Y      = 8'h81;
    localparam logic [7:0] ADDR_VIDEO_MODE    = 8'h82;
    localparam logic [7:0] ADDR_COLLISION     = 8'h83;
    localparam logic [7:0] ADDR_SPRITE_EFFECT = 8'h8D;
    localparam logic [7:0] ADDR_CONFIG_MODE   = 8'h90;
    localparam logic [7:0] ADDR_CONFIG_VIDEO  = 8'h93;

    // Palette window, matched against cpu_addr[15:4]
    localparam logic [11:0] PALETTE_PAGE = 12'h7F6;
    localparam int          PAL_PAGE_LSB = 4;

    // Per-sprite registers take the sprite number from cpu_addr[10:8]
    localparam int SPRITE_SEL_LSB = 8;

    // Enable bit in config_mode and config_video
    localparam int CFG_ENABLE_BIT = 0;

    // Control state seen by both pipeline stages
    typedef struct packed {
        logic [7:0] screen_x;
        logic [7:0] screen_y;
        logic [7:0] video_mode;  // Raw code, decoded in the fetch stage
        logic       fx_enable;   // config_mode bit 0
        logic       mode_enable; // config_video bit 0
    } ctrl_t;

endpackage

`default_nettype wire

//--- gx_pixel_pkg.sv
`default_nettype none

package gx_pixel_pkg;

    // Palette size
    localparam int NUM_PALETTE = 16;
    localparam int PAL_IDX_W   = 4;

    // One colour channel, 2 bits like the output pins
    typedef logic [1:0] chan_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    localparam rgb_t RGB_BLACK = '{red: 2'd0, green: 2'd0, blue: 2'd0};
    localparam rgb_t RGB_WHITE = '{red: 2'd3, green: 2'd3, blue: 2'd3};

    // Background modes, unknown codes fall back to normal
    typedef enum logic [7:0] {
        VM_NORMAL        = 8'd0,
        VM_DOUBLE_WIDTH  = 8'd1,
        VM_DOUBLE_HEIGHT = 8'd2,
        VM_INTERLACED    = 8'd3,
        VM_SCANLINE      = 8'd4,
        VM_SHADOW        = 8'd5,
        VM_GHOST         = 8'd6
    } video_mode_e;

    // Per-sprite effects, unknown codes fall back to normal
    typedef enum logic [7:0] {
        FX_NORMAL    = 8'd0,
        FX_OUTLINE   = 8'd1,
        FX_SHADOW    = 8'd2,
        FX_GLOW      = 8'd3,
        FX_INVERT    = 8'd4,
        FX_GRAYSCALE = 8'd5
    } sprite_effect_e;

    // One pixel between fetch and effect stage
    typedef struct packed {
        logic           valid;       // Active display
        logic           is_sprite;
        logic           transparent; // Sprite index 0
        logic           x_odd;
        logic           y_odd;
        rgb_t           colour;
        video_mode_e    mode;
        sprite_effect_e effect;
    } pix_t;

endpackage

`default_nettype wire

//--- gx_cpu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gx_cpu_regs (
    input  wire                                  clk_sys,
    input  wire                                  reset,
    input  wire                                  run,
    input  wire  [15:0]                          cpu_addr,
    input  wire  [7:0]                           cpu_data,
    input  wire                                  cpu_wr,
    input  wire                                  draw_sprite,
    input  wire  [gx_regs_pkg::SPRITE_IDX_W-1:0] sprite_id,
    output gx_regs_pkg::ctrl_t                   ctrl,
    output gx_pixel_pkg::rgb_t                   palette [gx_pixel_pkg::NUM_PALETTE],
    output gx_pixel_pkg::sprite_effect_e         sprite_effect [gx_regs_pkg::NUM_SPRITES],
    output logic [7:0]                           collision_reg,
    output logic [7:0]                           config_reg
);

    logic [7:0] screen_x_q;
    logic [7:0] screen_y_q;
    logic [7:0] video_mode_q;
    logic       mode_enable_q; // Only bit 0 of config_video has a meaning

    // Address decode
    logic [7:0]                           reg_sel;
    logic [gx_regs_pkg::SPRITE_IDX_W-1:0] sprite_sel;
    logic [gx_pixel_pkg::PAL_IDX_W-1:0]   pal_sel;
    logic                                 pal_wr;

    assign reg_sel    = cpu_addr[7:0];
    assign sprite_sel = cpu_addr[gx_regs_pkg::SPRITE_SEL_LSB +: gx_regs_pkg::SPRITE_IDX_W];
    assign pal_sel    = cpu_addr[gx_pixel_pkg::PAL_IDX_W-1:0];
    assign pal_wr     = cpu_wr &&
                        (cpu_addr[15:gx_regs_pkg::PAL_PAGE_LSB] == gx_regs_pkg::PALETTE_PAGE);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            screen_x_q    <= 8'h00;
            screen_y_q    <= 8'h00;
            video_mode_q  <= 8'h00;
            mode_enable_q <= 1'b0;
            collision_reg <= 8'h00;
            config_reg    <= 8'h00;
            for (int i = 0; i < gx_pixel_pkg::NUM_PALETTE; i++) begin
                palette[i] <= gx_pixel_pkg::RGB_BLACK;
            end
            for (int i = 0; i < gx_regs_pkg::NUM_SPRITES; i++) begin
                sprite_effect[i] <= gx_pixel_pkg::FX_NORMAL;
            end
        end else if (run) begin
            // Drawn sprite clears its flag, a CPU write below overrides
            if (draw_sprite) begin
                collision_reg[sprite_id] <= 1'b0;
            end

            if (cpu_wr) begin
                case (reg_sel)
                    gx_regs_pkg::ADDR_SCREEN_X:   screen_x_q    <= cpu_data;
                    gx_regs_pkg::ADDR_SCREEN_Y:   screen_y_q    <= cpu_data;
                    gx_regs_pkg::ADDR_VIDEO_MODE: video_mode_q  <= cpu_data;
                    gx_regs_pkg::ADDR_COLLISION:  collision_reg <= cpu_data;
                    gx_regs_pkg::ADDR_SPRITE_EFFECT: begin
                        sprite_effect[sprite_sel] <= gx_pixel_pkg::sprite_effect_e'(cpu_data);
                    end
                    gx_regs_pkg::ADDR_CONFIG_MODE: config_reg <= cpu_data;
                    gx_regs_pkg::ADDR_CONFIG_VIDEO: begin
                        mode_enable_q <= cpu_data[gx_regs_pkg::CFG_ENABLE_BIT];
                    end
                    default: ;
                endcase
            end

            // Page 7F6 sits below the register map, so both decodes run side by side
            if (pal_wr) begin
                palette[pal_sel] <= gx_pixel_pkg::rgb_t'(cpu_data[$bits(gx_pixel_pkg::rgb_t)-1:0]);
            end
        end
    end

    // Control bundle for both stages
    always_comb begin
        ctrl.screen_x    = screen_x_q;
        ctrl.screen_y    = screen_y_q;
        ctrl.video_mode  = video_mode_q;
        ctrl.fx_enable   = config_reg[gx_regs_pkg::CFG_ENABLE_BIT];
        ctrl.mode_enable = mode_enable_q;
    end

endmodule

`default_nettype wire

//--- gx_pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module gx_pixel_fetch (
    input  wire                                  clk_sys,
    input  wire                                  reset,
    input  wire                                  run,
    input  wire gx_regs_pkg::ctrl_t              ctrl,
    input  wire gx_pixel_pkg::rgb_t              palette [gx_pixel_pkg::NUM_PALETTE],
    input  wire gx_pixel_pkg::sprite_effect_e    sprite_effect [gx_regs_pkg::NUM_SPRITES],
    input  wire gx_pixel_pkg::chan_t             r_in,
    input  wire gx_pixel_pkg::chan_t             g_in,
    input  wire gx_pixel_pkg::chan_t             b_in,
    input  wire                                  hblank,
    input  wire                                  vblank,
    input  wire  [7:0]                           sprite_pixel,
    input  wire                                  sprite_active,
    input  wire  [gx_regs_pkg::SPRITE_IDX_W-1:0] sprite_id,
    output gx_pixel_pkg::pix_t                   pix,
    output logic                                 draw_sprite
);

    localparam int PAD_W = gx_pixel_pkg::PAL_IDX_W - $bits(gx_pixel_pkg::chan_t);

    logic                               active;
    logic [gx_pixel_pkg::PAL_IDX_W-1:0] r_idx;
    logic [gx_pixel_pkg::PAL_IDX_W-1:0] g_idx;
    logic [gx_pixel_pkg::PAL_IDX_W-1:0] b_idx;
    logic [gx_pixel_pkg::PAL_IDX_W-1:0] spr_idx;
    gx_pixel_pkg::rgb_t                 bg_colour;
    gx_pixel_pkg::pix_t                 pix_next;

    assign active      = !hblank && !vblank;
    assign draw_sprite = active && sprite_active; // Collision clear term

    // Background channels index the low palette entries
    assign r_idx   = {{PAD_W{1'b0}}, r_in};
    assign g_idx   = {{PAD_W{1'b0}}, g_in};
    assign b_idx   = {{PAD_W{1'b0}}, b_in};
    assign spr_idx = sprite_pixel[gx_pixel_pkg::PAL_IDX_W-1:0];

    always_comb begin
        bg_colour.red   = palette[r_idx].red;   // Each channel from its own entry
        bg_colour.green = palette[g_idx].green;
        bg_colour.blue  = palette[b_idx].blue;
    end

    always_comb begin
        pix_next.valid       = active;
        pix_next.is_sprite   = sprite_active;
        pix_next.transparent = (spr_idx == '0);
        pix_next.x_odd       = ctrl.screen_x[0];
        pix_next.y_odd       = ctrl.screen_y[0];
        pix_next.colour      = sprite_active ? palette[spr_idx] : bg_colour;
        pix_next.effect      = sprite_effect[sprite_id];
        if (ctrl.mode_enable) begin
            pix_next.mode = gx_pixel_pkg::video_mode_e'(ctrl.video_mode);
        end else begin
            pix_next.mode = gx_pixel_pkg::VM_NORMAL; // Video effects off
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix <= '0;
        end else if (run) begin
            pix <= pix_next;
        end
    end

endmodule

`default_nettype wire

//--- gx_effect_unit.sv
`timescale 1ns/1ps
`default_nettype none

module gx_effect_unit (
    input  wire                       clk_sys,
    input  wire                       reset,
    input  wire                       run,
    input  wire                       fx_enable,
    input  wire gx_pixel_pkg::pix_t   pix,
    output gx_pixel_pkg::chan_t       r_out,
    output gx_pixel_pkg::chan_t       g_out,
    output gx_pixel_pkg::chan_t       b_out
);

    gx_pixel_pkg::rgb_t shaped;
    gx_pixel_pkg::rgb_t out_q;
    logic               hold;   // Keep the previous output

    function automatic gx_pixel_pkg::rgb_t halve(gx_pixel_pkg::rgb_t c);
        gx_pixel_pkg::rgb_t res;
        res.red   = c.red >> 1;
        res.green = c.green >> 1;
        res.blue  = c.blue >> 1;
        return res;
    endfunction

    // Plus 2 then halve, one channel
    function automatic gx_pixel_pkg::chan_t glow_chan(gx_pixel_pkg::chan_t c);
        logic [2:0] sum;
        sum = {1'b0, c} + 3'd2;
        return sum[2:1];
    endfunction

    function automatic gx_pixel_pkg::rgb_t glow(gx_pixel_pkg::rgb_t c);
        gx_pixel_pkg::rgb_t res;
        res.red   = glow_chan(c.red);
        res.green = glow_chan(c.green);
        res.blue  = glow_chan(c.blue);
        return res;
    endfunction

    function automatic gx_pixel_pkg::rgb_t gray(gx_pixel_pkg::rgb_t c);
        logic [3:0] sum;
        logic [3:0] avg;
        sum = {2'b00, c.red} + {2'b00, c.green} + {2'b00, c.blue};
        avg = sum / 4'd3; // At most 3
        return '{red: avg[1:0], green: avg[1:0], blue: avg[1:0]};
    endfunction

    always_comb begin
        shaped = pix.colour;
        hold   = 1'b0;
        if (pix.is_sprite) begin
            case (pix.effect)
                gx_pixel_pkg::FX_OUTLINE: begin
                    if (pix.transparent) begin
                        shaped = gx_pixel_pkg::RGB_WHITE;
                    end
                end
                gx_pixel_pkg::FX_SHADOW:    shaped = halve(pix.colour);
                gx_pixel_pkg::FX_GLOW:      shaped = glow(pix.colour);
                gx_pixel_pkg::FX_INVERT:    shaped = ~pix.colour; // 3 minus each channel
                gx_pixel_pkg::FX_GRAYSCALE: shaped = gray(pix.colour);
                default: ;
            endcase
        end else begin
            case (pix.mode)
                gx_pixel_pkg::VM_DOUBLE_WIDTH:  hold = pix.x_odd;
                gx_pixel_pkg::VM_DOUBLE_HEIGHT: hold = pix.y_odd;
                gx_pixel_pkg::VM_INTERLACED: begin
                    if (pix.y_odd) begin
                        shaped = gx_pixel_pkg::RGB_BLACK;
                    end
                end
                gx_pixel_pkg::VM_SCANLINE: begin
                    if (pix.y_odd) begin
                        shaped = halve(pix.colour);
                    end
                end
                gx_pixel_pkg::VM_SHADOW: shaped = halve(pix.colour);
                gx_pixel_pkg::VM_GHOST:  shaped = glow(pix.colour);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_q <= gx_pixel_pkg::RGB_BLACK;
        end else if (run) begin
            if (!fx_enable) begin
                out_q <= gx_pixel_pkg::RGB_BLACK; // Master enable off
            end else if (pix.valid && !hold) begin
                out_q <= shaped;
            end
        end
    end

    assign r_out = out_q.red;
    assign g_out = out_q.green;
    assign b_out = out_q.blue;

endmodule

`default_nettype wire

//--- gx4000_video.sv
`timescale 1ns/1ps
`default_nettype none

module gx4000_video (
    input  wire                                  clk_sys,
    input  wire                                  reset,
    input  wire                                  gx4000_mode,
    input  wire  [15:0]                          cpu_addr,
    input  wire  [7:0]                           cpu_data,
    input  wire                                  cpu_wr,
    input  wire gx_pixel_pkg::chan_t             r_in,
    input  wire gx_pixel_pkg::chan_t             g_in,
    input  wire gx_pixel_pkg::chan_t             b_in,
    input  wire                                  hblank,
    input  wire                                  vblank,
    input  wire  [7:0]                           sprite_pixel,
    input  wire                                  sprite_active,
    input  wire  [gx_regs_pkg::SPRITE_IDX_W-1:0] sprite_id,
    output gx_pixel_pkg::chan_t                  r_out,
    output gx_pixel_pkg::chan_t                  g_out,
    output gx_pixel_pkg::chan_t                  b_out,
    output logic [7:0]                           collision_reg,
    output logic [7:0]                           config_reg
);

    gx_regs_pkg::ctrl_t           ctrl;
    gx_pixel_pkg::rgb_t           palette [gx_pixel_pkg::NUM_PALETTE];
    gx_pixel_pkg::sprite_effect_e sprite_effect [gx_regs_pkg::NUM_SPRITES];
    gx_pixel_pkg::pix_t           pix;
    logic                         draw_sprite;

    gx_cpu_regs u_regs (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .run           (gx4000_mode),
        .cpu_addr      (cpu_addr),
        .cpu_data      (cpu_data),
        .cpu_wr        (cpu_wr),
        .draw_sprite   (draw_sprite),
        .sprite_id     (sprite_id),
        .ctrl          (ctrl),
        .palette       (palette),
        .sprite_effect (sprite_effect),
        .collision_reg (collision_reg),
        .config_reg    (config_reg)
    );

    // Stage one, palette lookup
    gx_pixel_fetch u_fetch (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .run           (gx4000_mode),
        .ctrl          (ctrl),
        .palette       (palette),
        .sprite_effect (sprite_effect),
        .r_in          (r_in),
        .g_in          (g_in),
        .b_in          (b_in),
        .hblank        (hblank),
        .vblank        (vblank),
        .sprite_pixel  (sprite_pixel),
        .sprite_active (sprite_active),
        .sprite_id     (sprite_id),
        .pix           (pix),
        .draw_sprite   (draw_sprite)
    );

    // Stage two, shaping and output register
    gx_effect_unit u_effect (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .run       (gx4000_mode),
        .fx_enable (ctrl.fx_enable),
        .pix       (pix),
        .r_out     (r_out),
        .g_out     (g_out),
        .b_out     (b_out)
    );

endmodule

`default_nettype wire

//--- tb_gx4000_video.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gx4000_video;

    localparam int MAX_CYCLES = 20000;

    // One pixel held in the reference pipeline
    typedef struct packed {
        logic               valid;
        logic               is_sprite;
        logic               transparent;
        logic               x_odd;
        logic               y_odd;
        gx_pixel_pkg::rgb_t colour;
        logic [7:0]         mode;
        logic [7:0]         effect;
    } model_pix_t;

    logic        clk_sys;
    logic        reset;
    logic        gx4000_mode;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_data;
    logic        cpu_wr;
    logic [1:0]  r_in;
    logic [1:0]  g_in;
    logic [1:0]  b_in;
    logic        hblank;
    logic        vblank;
    logic [7:0]  sprite_pixel;
    logic        sprite_active;
    logic [2:0]  sprite_id;
    logic [1:0]  r_out;
    logic [1:0]  g_out;
    logic [1:0]  b_out;
    logic [7:0]  collision_reg;
    logic [7:0]  config_reg;

    // Reference model of the register file
    logic [7:0]         m_screen_x;
    logic [7:0]         m_screen_y;
    logic [7:0]         m_video_mode;
    logic               m_mode_enable;
    logic [7:0]         m_config;
    logic [7:0]         m_collision;
    gx_pixel_pkg::rgb_t m_palette [gx_pixel_pkg::NUM_PALETTE];
    logic [7:0]         m_effect [gx_regs_pkg::NUM_SPRITES];
    model_pix_t         fetch_q;  // First queue entry
    gx_pixel_pkg::rgb_t exp_out;  // Second entry holds the predicted output
    logic [31:0]        lfsr_state;

    gx4000_video DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    function logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Output register contents after one more edge
    function automatic gx_pixel_pkg::rgb_t predict_out(gx_pixel_pkg::rgb_t cur, model_pix_t p,
                                                       logic fx_on);
        int ch [3];
        int sum;
        ch[0] = p.colour.red;
        ch[1] = p.colour.green;
        ch[2] = p.colour.blue;
        sum = ch[0] + ch[1] + ch[2];
        if (!fx_on) return '0;
        if (!p.valid) return cur;
        if (!p.is_sprite && ((p.mode == 8'd1 && p.x_odd) || (p.mode == 8'd2 && p.y_odd))) begin
            return cur; // Pixel repeat
        end
        for (int i = 0; i < 3; i++) begin
            if (p.is_sprite) begin
                case (p.effect)
                    8'd1: ch[i] = p.transparent ? 3 : ch[i];
                    8'd2: ch[i] = ch[i] / 2;
                    8'd3: ch[i] = (ch[i] + 2) / 2;
                    8'd4: ch[i] = 3 - ch[i];
                    8'd5: ch[i] = sum / 3;
                    default: ;
                endcase
            end else begin
                case (p.mode)
                    8'd3: ch[i] = p.y_odd ? 0 : ch[i];
                    8'd4: ch[i] = p.y_odd ? ch[i] / 2 : ch[i];
                    8'd5: ch[i] = ch[i] / 2;
                    8'd6: ch[i] = (ch[i] + 2) / 2;
                    default: ;
                endcase
            end
        end
        return '{red: 2'(ch[0]), green: 2'(ch[1]), blue: 2'(ch[2])};
    endfunction

    function automatic model_pix_t capture_pixel();
        model_pix_t p;
        p.valid       = !hblank && !vblank;
        p.is_sprite   = sprite_active;
        p.transparent = (sprite_pixel[3:0] == 4'd0);
        p.x_odd       = m_screen_x[0];
        p.y_odd       = m_screen_y[0];
        p.colour      = m_palette[sprite_pixel[3:0]];
        if (!sprite_active) begin
            p.colour.red   = m_palette[{2'b00, r_in}].red;
            p.colour.green = m_palette[{2'b00, g_in}].green;
            p.colour.blue  = m_palette[{2'b00, b_in}].blue;
        end
        p.mode   = m_mode_enable ? m_video_mode : 8'd0;
        p.effect = m_effect[sprite_id];
        return p;
    endfunction

    always @(posedge clk_sys) begin
        if (reset) begin
            m_screen_x    <= '0;
            m_screen_y    <= '0;
            m_video_mode  <= '0;
            m_mode_enable <= 1'b0;
            m_config      <= '0;
            m_collision   <= '0;
            fetch_q       <= '0;
            exp_out       <= '0;
            for (int i = 0; i < gx_pixel_pkg::NUM_PALETTE; i++) m_palette[i] <= '0;
            for (int i = 0; i < gx_regs_pkg::NUM_SPRITES; i++) m_effect[i] <= '0;
        end else if (gx4000_mode) begin
            exp_out <= predict_out(exp_out, fetch_q, m_config[0]);
            fetch_q <= capture_pixel();
            if (sprite_active && !hblank && !vblank) m_collision[sprite_id] <= 1'b0;
            if (cpu_wr) begin
                case (cpu_addr[7:0])  // Later assignment wins over the clear above
                    gx_regs_pkg::ADDR_SCREEN_X:      m_screen_x <= cpu_data;
                    gx_regs_pkg::ADDR_SCREEN_Y:      m_screen_y <= cpu_data;
                    gx_regs_pkg::ADDR_VIDEO_MODE:    m_video_mode <= cpu_data;
                    gx_regs_pkg::ADDR_COLLISION:     m_collision <= cpu_data;
                    gx_regs_pkg::ADDR_SPRITE_EFFECT: m_effect[cpu_addr[10:8]] <= cpu_data;
                    gx_regs_pkg::ADDR_CONFIG_MODE:   m_config <= cpu_data;
                    gx_regs_pkg::ADDR_CONFIG_VIDEO:  m_mode_enable <= cpu_data[0];
                    default: ;
                endcase
                if (cpu_addr[15:4] == 12'h7F6) m_palette[cpu_addr[3:0]] <= cpu_data[5:0];
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] want);
        $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, want);
        $display("Regression failed");
        $fatal(1);
    endtask

    assert property (@(posedge clk_sys) disable iff (reset) r_out == exp_out.red)
        else report_mismatch("r_out", 8'($sampled(r_out)), 8'($sampled(exp_out.red)));
    assert property (@(posedge clk_sys) disable iff (reset) g_out == exp_out.green)
        else report_mismatch("g_out", 8'($sampled(g_out)), 8'($sampled(exp_out.green)));
    assert property (@(posedge clk_sys) disable iff (reset) b_out == exp_out.blue)
        else report_mismatch("b_out", 8'($sampled(b_out)), 8'($sampled(exp_out.blue)));
    assert property (@(posedge clk_sys) disable iff (reset) collision_reg == m_collision)
        else report_mismatch("collision_reg", $sampled(collision_reg), $sampled(m_collision));
    assert property (@(posedge clk_sys) disable iff (reset) config_reg == m_config)
        else report_mismatch("config_reg", $sampled(config_reg), $sampled(m_config));

    // Called at a falling edge, returns at the next one
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_data = data;
        cpu_wr   = 1'b1;
        @(negedge clk_sys);
        cpu_wr = 1'b0;
    endtask

    task automatic drive_pixel(input logic sprite, input logic [2:0] id, input logic [7:0] spix);
        r_in          = 2'(rand_bits(2));
        g_in          = 2'(rand_bits(2));
        b_in          = 2'(rand_bits(2));
        hblank        = 1'b0;
        vblank        = 1'b0;
        sprite_active = sprite;
        sprite_id     = id;
        sprite_pixel  = spix;
        @(negedge clk_sys);
    endtask

    task automatic wait_collision_clear(input int k);
        int n;
        n = 0;
        while (collision_reg[k] !== 1'b0) begin
            if (n == 8) begin
                $display("Collision bit %0d was not cleared after its sprite was drawn", k);
                $display("Regression failed");
                $fatal(1);
            end
            n++;
            @(negedge clk_sys);
        end
    endtask

    initial begin : watchdog
        for (int i = 0; i < MAX_CYCLES; i++) @(posedge clk_sys);
        $display("Simulation ran past %0d cycles without finishing", MAX_CYCLES);
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        logic [2:0] k;
        lfsr_state    = 32'hb9174f43;
        reset         = 1'b1;
        gx4000_mode   = 1'b1;
        cpu_addr      = '0;
        cpu_data      = '0;
        cpu_wr        = 1'b0;
        r_in          = '0;
        g_in          = '0;
        b_in          = '0;
        hblank        = 1'b1;
        vblank        = 1'b1;
        sprite_pixel  = '0;
        sprite_active = 1'b0;
        sprite_id     = '0;
        repeat (8) @(negedge clk_sys);
        reset = 1'b0;

        for (int i = 0; i < gx_pixel_pkg::NUM_PALETTE; i++) begin
            cpu_write({gx_regs_pkg::PALETTE_PAGE, 4'(i)}, 8'(rand_bits(8)));
        end
        repeat (6) drive_pixel(1'b0, 3'd0, 8'd0); // Master enable still off
        cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_MODE}, 8'h01);
        cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_VIDEO}, 8'h01);
        repeat (32) drive_pixel(1'b0, 3'd0, 8'd0);

        // Every mode over all parities with video effects on and then off
        for (int en = 1; en >= 0; en--) begin
            cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_VIDEO}, 8'(en));
            for (int m = 0; m < 8; m++) begin
                cpu_write({8'h00, gx_regs_pkg::ADDR_VIDEO_MODE}, 8'(m));
                for (int par = 0; par < 4; par++) begin
                    cpu_write({8'h00, gx_regs_pkg::ADDR_SCREEN_X}, 8'(rand_bits(7) * 2 + par % 2));
                    cpu_write({8'h00, gx_regs_pkg::ADDR_SCREEN_Y}, 8'(rand_bits(7) * 2 + par / 2));
                    repeat (4) drive_pixel(1'b0, 3'd0, 8'd0);
                end
            end
        end

        for (int e = 0; e < 7; e++) begin
            k = 3'(rand_bits(3));
            cpu_write({5'd0, k, gx_regs_pkg::ADDR_SPRITE_EFFECT}, 8'(e));
            repeat (6) drive_pixel(1'b1, k, 8'(rand_bits(8)));
            drive_pixel(1'b1, k, {4'(rand_bits(4)), 4'h0}); // Index 0
        end

        cpu_write({8'h00, gx_regs_pkg::ADDR_COLLISION}, 8'hFF);
        for (int i = 0; i < gx_regs_pkg::NUM_SPRITES; i++) begin
            drive_pixel(1'b1, 3'(i), 8'(rand_bits(8)));
            wait_collision_clear(i);
        end
        drive_pixel(1'b1, 3'd5, 8'h07);
        cpu_write({8'h00, gx_regs_pkg::ADDR_COLLISION}, 8'hA5); // Bit 5 set by the write
        cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_MODE}, 8'(rand_bits(8)) | 8'h01);

        // Random blanking with sprites mixed in
        for (int i = 0; i < 32; i++) begin
            hblank        = rand_bits(1) == 1;
            vblank        = rand_bits(1) == 1;
            sprite_active = rand_bits(1) == 1;
            sprite_id     = 3'(rand_bits(3));
            sprite_pixel  = 8'(rand_bits(8));
            @(negedge clk_sys);
        end

        gx4000_mode = 1'b0;
        cpu_write({gx_regs_pkg::PALETTE_PAGE, 4'd1}, 8'h3F);
        cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_MODE}, 8'h00);
        cpu_write({8'h00, gx_regs_pkg::ADDR_COLLISION}, 8'h00);
        repeat (6) drive_pixel(1'b1, 3'(rand_bits(3)), 8'(rand_bits(8)));
        gx4000_mode = 1'b1;
        repeat (16) drive_pixel(1'b0, 3'd0, 8'd0);
        cpu_write({8'h00, gx_regs_pkg::ADDR_CONFIG_MODE}, 8'h00);
        repeat (4) drive_pixel(1'b0, 3'd0, 8'd0);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
gx_regs_pkg.sv
gx_pixel_pkg.sv
gx_cpu_regs.sv
gx_pixel_fetch.sv
gx_effect_unit.sv
gx4000_video.sv
tb_gx4000_video.sv
